// ==== hmr_cfg_pkg.sv ====
package hmr_cfg_pkg;

  // Core and group counts for sequential grouping
  localparam int unsigned NUM_CORES      = 6;
  localparam int unsigned NUM_DMR_GROUPS = NUM_CORES / 2;
  localparam int unsigned NUM_TMR_GROUPS = NUM_CORES / 3;
  // One recovery unit per group of the mode with the most groups
  localparam int unsigned NUM_RR_UNITS   =
    (NUM_DMR_GROUPS > NUM_TMR_GROUPS) ? NUM_DMR_GROUPS : NUM_TMR_GROUPS;

  localparam int unsigned CFG_DATA_WIDTH = 32;

  typedef enum logic [1:0] {
    MODE_INDEP = 2'd0,
    MODE_DMR   = 2'd1,
    MODE_TMR   = 2'd2
  } hmr_mode_e;

  typedef enum logic {
    CFG_MODE_REG   = 1'b0,
    CFG_STATUS_REG = 1'b1
  } cfg_addr_e;

  // Four-phase request, fields held stable while req is high
  typedef struct packed {
    logic                      req;
    logic                      we;
    cfg_addr_e                 addr;
    logic [CFG_DATA_WIDTH-1:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic                      ack;
    logic [CFG_DATA_WIDTH-1:0] rdata;
  } cfg_rsp_t;

  // Mode register, mode sits in the two low bits
  typedef struct packed {
    logic [28:0] reserved;
    logic        rr_enable;
    hmr_mode_e   mode;
  } cfg_reg_t;

endpackage

// ==== hmr_rr_pkg.sv ====
package hmr_rr_pkg;

  localparam int unsigned DATA_WIDTH        = 32;
  // Widest register file address any core may use
  localparam int unsigned MAX_RF_ADDR_WIDTH = 5;

  // Per-cycle state sent by every core
  typedef struct packed {
    logic                         rf_we;
    logic [MAX_RF_ADDR_WIDTH-1:0] rf_addr;
    logic [DATA_WIDTH-1:0]        rf_wdata;
    logic [DATA_WIDTH-1:0]        pc;
  } core_backup_t;

  typedef enum logic {
    RR_KIND_REG = 1'b0,
    RR_KIND_PC  = 1'b1
  } rr_kind_e;

  // Register file entry view
  typedef struct packed {
    logic [MAX_RF_ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0]        data;
  } rr_rf_entry_t;

  // PC view, upper bits unused
  typedef struct packed {
    logic [MAX_RF_ADDR_WIDTH-1:0] pad;
    logic [DATA_WIDTH-1:0]        value;
  } rr_pc_entry_t;

  // Payload is read through the view selected by the kind flag
  typedef union packed {
    rr_rf_entry_t rf;
    rr_pc_entry_t pc;
  } rr_payload_u;

  typedef struct packed {
    logic        valid;
    rr_kind_e    kind;
    rr_payload_u payload;
  } rr_bus_t;

endpackage

// ==== hmr_mode_ctrl.sv ====
`timescale 1ns/1ps

module hmr_mode_ctrl import hmr_cfg_pkg::*; (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  cfg_req_t                  cfg_req_i,
  output cfg_rsp_t                  cfg_rsp_o,
  input  logic [NUM_DMR_GROUPS-1:0] dmr_mismatch_i,
  input  logic [NUM_TMR_GROUPS-1:0] tmr_fail_i,
  input  logic [NUM_CORES-1:0]      tmr_disagree_i,
  input  logic [NUM_RR_UNITS-1:0]   unit_busy_i,
  output logic [NUM_DMR_GROUPS-1:0] dmr_failure_o,
  output logic [NUM_TMR_GROUPS-1:0] tmr_failure_o,
  output logic [NUM_CORES-1:0]      tmr_error_o,
  output hmr_mode_e                 mode_o,
  output logic [NUM_RR_UNITS-1:0]   backup_en_o,
  output logic [NUM_RR_UNITS-1:0]   recovery_start_o
);

  cfg_reg_t                  cfg_q;
  logic                      ack_q;
  logic [CFG_DATA_WIDTH-1:0] rdata_q;
  logic [NUM_RR_UNITS-1:0]   status_q;
  logic [NUM_RR_UNITS-1:0]   fail_q;
  logic [NUM_RR_UNITS-1:0]   start_q;
  logic [NUM_RR_UNITS-1:0]   unit_fail;
  logic                      dmr_active;
  logic                      tmr_active;
  logic                      new_req;

  assign dmr_active = cfg_q.rr_enable && (cfg_q.mode == MODE_DMR);
  assign tmr_active = cfg_q.rr_enable && (cfg_q.mode == MODE_TMR);

  // Request seen while ack is still low starts a new transfer
  assign new_req = cfg_req_i.req && !ack_q;

  assign dmr_failure_o = dmr_active ? dmr_mismatch_i : '0;
  assign tmr_failure_o = tmr_active ? tmr_fail_i : '0;
  assign tmr_error_o   = tmr_active ? tmr_disagree_i : '0;

  // Group g of either mode maps onto unit g
  assign unit_fail = NUM_RR_UNITS'(dmr_failure_o) | NUM_RR_UNITS'(tmr_failure_o);

  // A TMR group still stores the majority on a failure
  always_comb begin
    backup_en_o = '0;
    if (dmr_active) begin
      backup_en_o = NUM_RR_UNITS'(~dmr_mismatch_i);
    end else if (tmr_active) begin
      backup_en_o = NUM_RR_UNITS'({NUM_TMR_GROUPS{1'b1}});
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q    <= '0;
      ack_q    <= 1'b0;
      rdata_q  <= '0;
      status_q <= '0;
      fail_q   <= '0;
      start_q  <= '0;
    end else begin
      ack_q  <= cfg_req_i.req;
      fail_q <= unit_fail;
      // Start only on the first cycle of a failure and only for an idle unit
      start_q  <= unit_fail & ~fail_q & ~unit_busy_i;
      status_q <= status_q | unit_fail;
      if (new_req) begin
        if (cfg_req_i.we) begin
          if (cfg_req_i.addr == CFG_MODE_REG) begin
            cfg_q <= cfg_req_i.wdata;
          end else begin
            // Failures in the clearing cycle stay recorded
            status_q <= unit_fail;
          end
        end else if (cfg_req_i.addr == CFG_MODE_REG) begin
          rdata_q <= cfg_q;
        end else begin
          rdata_q <= CFG_DATA_WIDTH'(status_q);
        end
      end
    end
  end

  assign cfg_rsp_o.ack   = ack_q;
  assign cfg_rsp_o.rdata = rdata_q;

  assign mode_o           = cfg_q.mode;
  assign recovery_start_o = start_q;

  // Master must hold req until ack is seen
  a_ack_with_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(cfg_rsp_o.ack) |-> cfg_req_i.req)
    else $error("cfg ack rose while req was low");

  a_no_start_when_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (recovery_start_o & unit_busy_i) == '0)
    else $error("recovery start issued to a busy unit");

endmodule

// ==== hmr_dmr_checker.sv ====
`timescale 1ns/1ps

module hmr_dmr_checker import hmr_rr_pkg::*; (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  core_backup_t backup_a_i,
  input  core_backup_t backup_b_i,
  output core_backup_t backup_o,
  output logic         mismatch_o
);

  core_backup_t a_q;
  core_backup_t b_q;

  // Both words sampled together so the flag lines up with the forwarded word
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= backup_a_i;
      b_q <= backup_b_i;
    end
  end

  // Core a of the pair is forwarded, it is only stored when both agree
  assign backup_o = a_q;

  // Any differing bit flags the pair
  assign mismatch_o = |(a_q ^ b_q);

endmodule

// ==== hmr_tmr_voter.sv ====
`timescale 1ns/1ps

module hmr_tmr_voter import hmr_rr_pkg::*; (
  input  core_backup_t backup_a_i,
  input  core_backup_t backup_b_i,
  input  core_backup_t backup_c_i,
  output core_backup_t majority_o,
  output logic         fail_o,
  output logic [2:0]   disagree_o
);

  localparam int unsigned WordWidth = $bits(core_backup_t);

  logic [WordWidth-1:0] a;
  logic [WordWidth-1:0] b;
  logic [WordWidth-1:0] c;
  logic [WordWidth-1:0] maj;

  assign a = backup_a_i;
  assign b = backup_b_i;
  assign c = backup_c_i;

  // Two of three per bit
  assign maj = (a & b) | (a & c) | (b & c);

  assign majority_o = maj;

  // Index 0 is the lowest core of the triple
  assign disagree_o[0] = (a != maj);
  assign disagree_o[1] = (b != maj);
  assign disagree_o[2] = (c != maj);

  assign fail_o = |disagree_o;

endmodule

// ==== hmr_recovery_unit.sv ====
`timescale 1ns/1ps

module hmr_recovery_unit import hmr_rr_pkg::*; #(
  parameter int unsigned RfAddrWidth = 5
) (
  input  logic         clk_i,
  input  logic         arst_n_i,
  input  core_backup_t backup_i,
  input  logic         backup_en_i,
  input  logic         recovery_start_i,
  output logic         busy_o,
  output logic         setback_o,
  output logic         recovery_finished_o,
  output rr_bus_t      rr_bus_o
);

  localparam int unsigned NumRegs = 2 ** RfAddrWidth;
  // Counter value that sends the PC after the last register
  localparam logic [RfAddrWidth:0] PcSlot = (RfAddrWidth + 1)'(NumRegs);

  logic [DATA_WIDTH-1:0]  shadow_rf [NumRegs];
  logic [DATA_WIDTH-1:0]  shadow_pc;
  logic                   shadow_we;
  logic                   busy_q;
  logic [RfAddrWidth:0]   cnt_q;
  logic [RfAddrWidth-1:0] rd_addr;
  logic                   pc_slot;

  // Shadow state is frozen while it is being streamed out
  assign shadow_we = backup_en_i && !busy_q;

  always_ff @(posedge clk_i) begin
    if (shadow_we) begin
      if (backup_i.rf_we) begin
        shadow_rf[backup_i.rf_addr[RfAddrWidth-1:0]] <= backup_i.rf_wdata;
      end
      shadow_pc <= backup_i.pc;
    end
  end

  // Walks every register address and then one cycle for the PC
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (pc_slot) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (recovery_start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end
  end

  assign pc_slot = (cnt_q == PcSlot);
  assign rd_addr = cnt_q[RfAddrWidth-1:0];

  assign busy_o              = busy_q;
  assign setback_o           = busy_q;
  assign recovery_finished_o = busy_q && pc_slot;

  always_comb begin
    rr_bus_o       = '0;
    rr_bus_o.valid = busy_q;
    if (pc_slot) begin
      rr_bus_o.kind             = RR_KIND_PC;
      rr_bus_o.payload.pc.value = shadow_pc;
    end else begin
      rr_bus_o.kind            = RR_KIND_REG;
      rr_bus_o.payload.rf.addr = MAX_RF_ADDR_WIDTH'(rd_addr);
      rr_bus_o.payload.rf.data = shadow_rf[rd_addr];
    end
  end

  a_setback_matches_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    setback_o == rr_bus_o.valid)
    else $error("setback and recovery bus valid differ");

endmodule

// ==== hmr_rr_top.sv ====
`timescale 1ns/1ps

module hmr_rr_top import hmr_cfg_pkg::*, hmr_rr_pkg::*; #(
  parameter int unsigned RfAddrWidth = 5
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  cfg_req_t                           cfg_req_i,
  output cfg_rsp_t                           cfg_rsp_o,
  input  core_backup_t [NUM_CORES-1:0]       core_backup_i,
  output logic         [NUM_DMR_GROUPS-1:0]  dmr_failure_o,
  output logic         [NUM_TMR_GROUPS-1:0]  tmr_failure_o,
  output logic         [NUM_CORES-1:0]       tmr_error_o,
  output logic         [NUM_CORES-1:0]       core_setback_o,
  output rr_bus_t      [NUM_CORES-1:0]       core_recovery_o,
  output logic         [NUM_RR_UNITS-1:0]    recovery_finished_o
);

  hmr_mode_e                          mode;
  core_backup_t [NUM_DMR_GROUPS-1:0]  dmr_backup;
  logic         [NUM_DMR_GROUPS-1:0]  dmr_mismatch;
  core_backup_t [NUM_TMR_GROUPS-1:0]  tmr_majority;
  logic         [NUM_TMR_GROUPS-1:0]  tmr_fail;
  logic         [NUM_CORES-1:0]       tmr_disagree;
  core_backup_t [NUM_RR_UNITS-1:0]    unit_backup;
  logic         [NUM_RR_UNITS-1:0]    unit_backup_en;
  logic         [NUM_RR_UNITS-1:0]    unit_start;
  logic         [NUM_RR_UNITS-1:0]    unit_busy;
  logic         [NUM_RR_UNITS-1:0]    unit_setback;
  rr_bus_t      [NUM_RR_UNITS-1:0]    unit_bus;

  hmr_mode_ctrl u_mode_ctrl (
    .clk_i            ( clk_i          ),
    .arst_n_i         ( arst_n_i       ),
    .cfg_req_i        ( cfg_req_i      ),
    .cfg_rsp_o        ( cfg_rsp_o      ),
    .dmr_mismatch_i   ( dmr_mismatch   ),
    .tmr_fail_i       ( tmr_fail       ),
    .tmr_disagree_i   ( tmr_disagree   ),
    .unit_busy_i      ( unit_busy      ),
    .dmr_failure_o    ( dmr_failure_o  ),
    .tmr_failure_o    ( tmr_failure_o  ),
    .tmr_error_o      ( tmr_error_o    ),
    .mode_o           ( mode           ),
    .backup_en_o      ( unit_backup_en ),
    .recovery_start_o ( unit_start     )
  );

  // Pairs are cores 2g and 2g+1
  for (genvar g = 0; g < NUM_DMR_GROUPS; g++) begin : gen_dmr_checker
    hmr_dmr_checker u_checker (
      .clk_i      ( clk_i                ),
      .arst_n_i   ( arst_n_i             ),
      .backup_a_i ( core_backup_i[2*g]   ),
      .backup_b_i ( core_backup_i[2*g+1] ),
      .backup_o   ( dmr_backup[g]        ),
      .mismatch_o ( dmr_mismatch[g]      )
    );
  end

  // Triples are cores 3g to 3g+2
  for (genvar g = 0; g < NUM_TMR_GROUPS; g++) begin : gen_tmr_voter
    hmr_tmr_voter u_voter (
      .backup_a_i ( core_backup_i[3*g]     ),
      .backup_b_i ( core_backup_i[3*g+1]   ),
      .backup_c_i ( core_backup_i[3*g+2]   ),
      .majority_o ( tmr_majority[g]        ),
      .fail_o     ( tmr_fail[g]            ),
      .disagree_o ( tmr_disagree[3*g +: 3] )
    );
  end

  for (genvar g = 0; g < NUM_RR_UNITS; g++) begin : gen_rr_unit
    if (g < NUM_TMR_GROUPS) begin : gen_tmr_source
      assign unit_backup[g] = (mode == MODE_TMR) ? tmr_majority[g] : dmr_backup[g];
    end else begin : gen_dmr_source
      // No triple behind this unit, its enable stays low in TMR mode
      assign unit_backup[g] = dmr_backup[g];
    end

    hmr_recovery_unit #(
      .RfAddrWidth ( RfAddrWidth )
    ) u_rr_unit (
      .clk_i               ( clk_i                  ),
      .arst_n_i            ( arst_n_i               ),
      .backup_i            ( unit_backup[g]         ),
      .backup_en_i         ( unit_backup_en[g]      ),
      .recovery_start_i    ( unit_start[g]          ),
      .busy_o              ( unit_busy[g]           ),
      .setback_o           ( unit_setback[g]        ),
      .recovery_finished_o ( recovery_finished_o[g] ),
      .rr_bus_o            ( unit_bus[g]            )
    );
  end

  // Each core follows the unit of its group in the current mode
  for (genvar c = 0; c < NUM_CORES; c++) begin : gen_core_route
    localparam int unsigned DmrGrp = c / 2;
    localparam int unsigned TmrGrp = c / 3;

    assign core_recovery_o[c] = (mode == MODE_DMR) ? unit_bus[DmrGrp] :
                                (mode == MODE_TMR) ? unit_bus[TmrGrp] : '0;
    assign core_setback_o[c]  = (mode == MODE_DMR) ? unit_setback[DmrGrp] :
                                (mode == MODE_TMR) ? unit_setback[TmrGrp] : 1'b0;
  end

endmodule

// ==== tb_hmr_rr.sv ====
`timescale 1ns/1ps

module tb_hmr_rr import hmr_cfg_pkg::*, hmr_rr_pkg::*; ();

  logic                               clk_i;
  logic                               arst_n_i;
  cfg_req_t                           cfg_req;
  cfg_rsp_t                           cfg_rsp;
  core_backup_t [NUM_CORES-1:0]       core_backup;
  logic         [NUM_DMR_GROUPS-1:0]  dmr_failure;
  logic         [NUM_TMR_GROUPS-1:0]  tmr_failure;
  logic         [NUM_CORES-1:0]       tmr_error;
  logic         [NUM_CORES-1:0]       core_setback;
  rr_bus_t      [NUM_CORES-1:0]       core_recovery;
  logic         [NUM_RR_UNITS-1:0]    recovery_finished;

  int          seed = 36240;
  hmr_mode_e   cur_mode;
  logic        cur_rren;
  logic [31:0] cur_pc;
  logic [31:0] rdata;
  // Expected shadow state for each recovery unit
  logic [31:0] exp_rf [NUM_RR_UNITS][8];
  logic [31:0] exp_pc [NUM_RR_UNITS];

  hmr_rr_top #(
    .RfAddrWidth ( 3 )
  ) u_dut (
    .clk_i               ( clk_i             ),
    .arst_n_i            ( arst_n_i          ),
    .cfg_req_i           ( cfg_req           ),
    .cfg_rsp_o           ( cfg_rsp           ),
    .core_backup_i       ( core_backup       ),
    .dmr_failure_o       ( dmr_failure       ),
    .tmr_failure_o       ( tmr_failure       ),
    .tmr_error_o         ( tmr_error         ),
    .core_setback_o      ( core_setback      ),
    .core_recovery_o     ( core_recovery     ),
    .recovery_finished_o ( recovery_finished )
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp === act) else begin
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  endtask

  // Four-phase access where each ack edge follows req by one cycle
  task automatic cfg_access(input logic we, input cfg_addr_e addr, input logic [31:0] wdata,
                            output logic [31:0] rd);
    int n;
    @(posedge clk_i);
    #2;
    cfg_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    n = 0;
    @(negedge clk_i);
    while (!cfg_rsp.ack) begin
      n++;
      if (n > 4) report_timeout("cfg ack to rise");
      @(negedge clk_i);
    end
    expect_eq("cfg ack rise delay", 64'(1), 64'(n));
    rd = cfg_rsp.rdata;
    @(posedge clk_i);
    #2;
    cfg_req.req = 1'b0;
    n = 0;
    @(negedge clk_i);
    while (cfg_rsp.ack) begin
      n++;
      if (n > 4) report_timeout("cfg ack to fall");
      @(negedge clk_i);
    end
    expect_eq("cfg ack fall delay", 64'(1), 64'(n));
    if (we && addr == CFG_MODE_REG) begin
      cur_mode = hmr_mode_e'(wdata[1:0]);
      cur_rren = wdata[2];
    end
  endtask

  // One backup cycle with an optional corrupted core and the model update
  task automatic send_word(input int bad_core, input logic [31:0] flip, input logic we,
                           input logic [2:0] addr, input logic [31:0] data,
                           input logic [31:0] pc);
    core_backup_t w;
    logic         en;
    @(posedge clk_i);
    #2;
    w.rf_we    = we;
    w.rf_addr  = {2'b00, addr};
    w.rf_wdata = data;
    w.pc       = pc;
    for (int c = 0; c < NUM_CORES; c++) core_backup[c] = w;
    if (bad_core >= 0) core_backup[bad_core].rf_wdata = data ^ flip;
    cur_pc = pc;
    for (int u = 0; u < NUM_RR_UNITS; u++) begin
      en = 1'b0;
      if (cur_rren && cur_mode == MODE_DMR) en = (bad_core < 0) || (bad_core / 2 != u);
      if (cur_rren && cur_mode == MODE_TMR) en = (u < NUM_TMR_GROUPS);
      if (en) begin
        if (we) exp_rf[u][addr] = data;
        exp_pc[u] = pc;
      end
    end
  endtask

  task automatic send_idle();
    send_word(-1, 32'h0, 1'b0, 3'd0, 32'h0, cur_pc);
  endtask

  task automatic fill_regs();
    logic [31:0] d;
    for (int a = 0; a < 8; a++) begin
      d = $random(seed);
      send_word(-1, 32'h0, 1'b1, 3'(a), d, $random(seed));
    end
    send_idle();
    send_idle();
  endtask

  // Stream of 8 registers and then the PC on the cores in mask only
  task automatic check_recovery(input string name, input int unit, input logic [5:0] mask);
    int      n;
    rr_bus_t exp_bus;
    n = 0;
    @(negedge clk_i);
    while (core_setback == '0) begin
      n++;
      if (n > 8) report_timeout("setback to start");
      @(negedge clk_i);
    end
    for (int i = 0; i < 9; i++) begin
      expect_eq({name, " setback"}, 64'(mask), 64'(core_setback));
      expect_eq({name, " finished"}, 64'(i == 8 ? 3'(1 << unit) : 3'd0),
                64'(recovery_finished));
      exp_bus       = '0;
      exp_bus.valid = 1'b1;
      if (i < 8) begin
        exp_bus.kind            = RR_KIND_REG;
        exp_bus.payload.rf.addr = 5'(i);
        exp_bus.payload.rf.data = exp_rf[unit][i];
      end else begin
        exp_bus.kind             = RR_KIND_PC;
        exp_bus.payload.pc.value = exp_pc[unit];
      end
      for (int c = 0; c < NUM_CORES; c++) begin
        if (mask[c]) expect_eq({name, " bus"}, 64'(exp_bus), 64'(core_recovery[c]));
        else expect_eq({name, " idle core valid"}, 64'(0), 64'(core_recovery[c].valid));
      end
      @(negedge clk_i);
    end
    expect_eq({name, " setback end"}, 64'(0), 64'(core_setback));
  endtask

  // Mismatches must not reach any failure, setback or recovery output
  task automatic check_quiet(input string name, input int bad_core);
    send_word(bad_core, 32'h1, 1'b1, 3'd1, $random(seed), cur_pc);
    for (int i = 0; i < 4; i++) begin
      send_idle();
      @(negedge clk_i);
      expect_eq({name, " dmr failure"}, 64'(0), 64'(dmr_failure));
      expect_eq({name, " tmr failure"}, 64'(0), 64'(tmr_failure));
      expect_eq({name, " tmr error"}, 64'(0), 64'(tmr_error));
      expect_eq({name, " setback"}, 64'(0), 64'(core_setback));
      for (int c = 0; c < NUM_CORES; c++) begin
        expect_eq({name, " valid"}, 64'(0), 64'(core_recovery[c].valid));
      end
    end
  endtask

  initial begin
    #2ms;
    report_timeout("the whole test to end");
  end

  initial begin
    logic [31:0] d;
    logic [31:0] flip;
    logic [2:0]  a;
    cfg_req     = '0;
    core_backup = '0;
    arst_n_i    = 1'b0;
    cur_mode    = MODE_INDEP;
    cur_rren    = 1'b0;
    cur_pc      = '0;
    repeat (10) @(posedge clk_i);
    #2;
    arst_n_i = 1'b1;

    // Configuration write then read back
    cfg_access(1'b1, CFG_MODE_REG, 32'h6, rdata);
    cfg_access(1'b0, CFG_MODE_REG, 32'h0, rdata);
    expect_eq("cfg mode readback", 64'(32'h6), 64'(rdata));

    // TMR with core 4 corrupted
    fill_regs();
    a    = 3'($random(seed));
    d    = $random(seed);
    flip = $random(seed) | 32'h1;
    send_word(4, flip, 1'b1, a, d, $random(seed));
    @(negedge clk_i);
    expect_eq("tmr error", 64'(6'b010000), 64'(tmr_error));
    expect_eq("tmr failure", 64'(2'b10), 64'(tmr_failure));
    send_idle();
    check_recovery("tmr recovery", 1, 6'b111000);
    cfg_access(1'b0, CFG_STATUS_REG, 32'h0, rdata);
    expect_eq("tmr status", 64'(32'h2), 64'(rdata));
    cfg_access(1'b1, CFG_STATUS_REG, 32'h0, rdata);
    cfg_access(1'b0, CFG_STATUS_REG, 32'h0, rdata);
    expect_eq("tmr status clear", 64'(0), 64'(rdata));

    // DMR with pair 1 mismatched
    cfg_access(1'b1, CFG_MODE_REG, 32'h5, rdata);
    fill_regs();
    a    = 3'($random(seed));
    flip = $random(seed) | 32'h1;
    send_word(3, flip, 1'b1, a, $random(seed), $random(seed));
    @(negedge clk_i);
    expect_eq("dmr failure early", 64'(0), 64'(dmr_failure));
    send_idle();
    @(negedge clk_i);
    expect_eq("dmr failure", 64'(3'b010), 64'(dmr_failure));
    expect_eq("dmr tmr error", 64'(0), 64'(tmr_error));
    check_recovery("dmr recovery", 1, 6'b001100);
    cfg_access(1'b0, CFG_STATUS_REG, 32'h0, rdata);
    expect_eq("dmr status", 64'(32'h2), 64'(rdata));
    cfg_access(1'b1, CFG_STATUS_REG, 32'h0, rdata);
    cfg_access(1'b0, CFG_STATUS_REG, 32'h0, rdata);
    expect_eq("dmr status clear", 64'(0), 64'(rdata));

    // No recovery with rr_enable low nor in independent mode
    cfg_access(1'b1, CFG_MODE_REG, 32'h1, rdata);
    check_quiet("dmr rr off", 1);
    cfg_access(1'b1, CFG_MODE_REG, 32'h4, rdata);
    check_quiet("independent", 0);

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== verilog.f ====
hmr_cfg_pkg.sv
hmr_rr_pkg.sv
hmr_mode_ctrl.sv
hmr_dmr_checker.sv
hmr_tmr_voter.sv
hmr_recovery_unit.sv
hmr_rr_top.sv
tb_hmr_rr.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_hmr_rr -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_hmr_rr)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
